/* rtl/mole_pkg.sv */
package mole_pkg;

   localparam int kp_lines = 4;    // keypad rows, also columns
   localparam int holes = 16;
   localparam int dot_lines = 8;
   localparam int hole_w = 4;
   localparam int row_w = 3;
   localparam int seg_w = 7;

   localparam int game_time = 30;  // countdown start, in mole steps
   localparam int score_max = 99;

   localparam int key_div_default = 500000;
   localparam int mole_div_default = 25000000;
   localparam int dot_div_default = 2500;

   typedef logic [hole_w-1:0] hole_t;

   typedef struct packed {
      logic  valid;
      hole_t hole;
   } press_t;

   typedef struct packed {
      logic  shown;
      hole_t hole;
   } mole_t;

   typedef struct packed {
      logic [seg_w-1:0] tens;
      logic [seg_w-1:0] ones;
   } seg_pair_t;

   // fixed pop-up order
   localparam hole_t mole_order [0:holes-1] = '{
      4'd12, 4'd4, 4'd8, 4'd13, 4'd0, 4'd3, 4'd1, 4'd7,
      4'd14, 4'd5, 4'd9, 4'd2, 4'd11, 4'd6, 4'd10, 4'd15
   };

   // active low, bit 0 = a ... bit 6 = g
   localparam logic [seg_w-1:0] seg_font [0:9] = '{
      7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
      7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000
   };

endpackage

/* rtl/tick_divider.sv */
`timescale 1ns/10ps

module tick_divider #(
   parameter int div = 4
) (
   input  logic clk,
   input  logic rst,
   output logic tick
);

   localparam int cnt_w = (div > 1) ? $clog2(div) : 1;

   logic [cnt_w-1:0] cnt;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         cnt <= '0;
         tick <= 1'b0;
      end else begin
         tick <= (cnt == cnt_w'(div - 1));    // registered, lands div cycles out
         cnt <= (cnt == cnt_w'(div - 1)) ? '0 : cnt + 1'b1;
      end
   end

endmodule

/* rtl/keypad_scan.sv */
`timescale 1ns/10ps

module keypad_scan (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           key_tick,
   input  logic [mole_pkg::kp_lines-1:0]  keypad_col,
   output logic [mole_pkg::kp_lines-1:0]  keypad_row,
   output mole_pkg::press_t               press
);

   localparam int col_w = $clog2(mole_pkg::kp_lines);
   localparam logic [mole_pkg::kp_lines-1:0] row_first = {1'b1, {(mole_pkg::kp_lines-1){1'b0}}};

   logic [col_w-1:0]              row_idx;
   logic [mole_pkg::holes-1:0]    down;        // keys seen down at last scan
   logic [mole_pkg::kp_lines-1:0] col_down;    // index 0 is keypad_col msb
   logic [col_w-1:0]              first_col;
   logic                          any_down;
   mole_pkg::hole_t               hit;

   assign keypad_row = ~(row_first >> row_idx);   // one low line, msb first

   always_comb begin
      col_down = '0;
      any_down = 1'b0;
      first_col = '0;
      for (int c = mole_pkg::kp_lines - 1; c >= 0; c--) begin
         col_down[c] = ~keypad_col[mole_pkg::kp_lines-1-c];
         if (col_down[c]) begin
            first_col = col_w'(c);   // lowest index wins
            any_down = 1'b1;
         end
      end
   end

   assign hit = {row_idx, first_col};   // row * 4 + col

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         row_idx <= '0;
         down <= '0;
         press <= '0;
      end else begin
         press.valid <= 1'b0;
         if (key_tick) begin
            down[row_idx*mole_pkg::kp_lines +: mole_pkg::kp_lines] <= col_down;
            press.valid <= any_down && !down[hit];   // fresh press only
            press.hole <= hit;
            row_idx <= row_idx + 1'b1;
         end
      end
   end

endmodule

/* rtl/mole_sequencer.sv */
`timescale 1ns/10ps

module mole_sequencer (
   input  logic            clk,
   input  logic            rst,
   input  logic            mole_tick,
   output mole_pkg::mole_t mole
);

   logic [mole_pkg::hole_w-1:0] pos;   // wraps after 16 entries

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         pos <= '0;
         mole <= '0;
      end else if (mole_tick) begin
         mole.shown <= 1'b1;
         mole.hole <= mole_pkg::mole_order[pos];
         pos <= pos + 1'b1;
      end
   end

endmodule

/* rtl/dot_matrix_scan.sv */
`timescale 1ns/10ps

module dot_matrix_scan (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           dot_tick,
   input  mole_pkg::mole_t                mole,
   input  logic                           active,
   output logic [mole_pkg::dot_lines-1:0] dot_row,
   output logic [mole_pkg::dot_lines-1:0] dot_col
);

   localparam logic [mole_pkg::dot_lines-1:0] top_row = {1'b1, {(mole_pkg::dot_lines-1){1'b0}}};
   localparam logic [mole_pkg::dot_lines-1:0] left_pair = {2'b11, {(mole_pkg::dot_lines-2){1'b0}}};

   logic [mole_pkg::row_w-1:0]     r;
   logic [mole_pkg::dot_lines-1:0] pattern;

   // 2x2 block, rows 2*(h/4) and next, columns from h%4
   always_comb begin
      pattern = '0;
      if (active && mole.shown && (r[mole_pkg::row_w-1:1] == mole.hole[3:2]))
         pattern = left_pair >> {mole.hole[1:0], 1'b0};
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         r <= '0;
         dot_row <= '1;   // all rows off
         dot_col <= '0;
      end else if (dot_tick) begin
         dot_row <= ~(top_row >> r);
         dot_col <= pattern;
         r <= r + 1'b1;
      end
   end

endmodule

/* rtl/score_timer.sv */
`timescale 1ns/10ps

module score_timer (
   input  logic             clk,
   input  logic             rst,
   input  logic             mole_tick,
   input  mole_pkg::press_t press,
   input  mole_pkg::mole_t  mole,
   output logic [6:0]       score,
   output logic [4:0]       time_left,
   output logic             active
);

   logic hit;

   assign hit = press.valid && mole.shown && active && (press.hole == mole.hole);

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         score <= '0;
         time_left <= 5'(mole_pkg::game_time);
         active <= 1'b1;
      end else begin
         if (hit && (score != 7'(mole_pkg::score_max)))
            score <= score + 1'b1;   // saturates at 99
         if (mole_tick && active) begin
            time_left <= time_left - 1'b1;
            if (time_left == 5'd1)
               active <= 1'b0;   // game over, held until reset
         end
      end
   end

endmodule

/* rtl/seg_pair_decoder.sv */
`timescale 1ns/10ps

module seg_pair_decoder (
   input  logic [6:0]          value,
   output mole_pkg::seg_pair_t seg
);

   logic [6:0] tens;
   logic [6:0] ones;

   assign tens = value / 7'd10;
   assign ones = value % 7'd10;

   always_comb begin
      seg.ones = mole_pkg::seg_font[ones[3:0]];
      if (tens > 7'd9)
         seg.tens = '1;   // out of range, blank
      else
         seg.tens = mole_pkg::seg_font[tens[3:0]];
   end

endmodule

/* rtl/whack_top.sv */
`timescale 1ns/10ps

module whack_top #(
   parameter int key_div = mole_pkg::key_div_default,
   parameter int mole_div = mole_pkg::mole_div_default,
   parameter int dot_div = mole_pkg::dot_div_default
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [mole_pkg::kp_lines-1:0]  keypad_col,
   output logic [mole_pkg::kp_lines-1:0]  keypad_row,
   output logic [mole_pkg::dot_lines-1:0] dot_row,
   output logic [mole_pkg::dot_lines-1:0] dot_col,
   output mole_pkg::seg_pair_t            score_seg,
   output mole_pkg::seg_pair_t            time_seg
);

   logic             key_tick;
   logic             mole_tick;
   logic             dot_tick;
   mole_pkg::press_t press;
   mole_pkg::mole_t  mole;
   logic [6:0]       score;
   logic [4:0]       time_left;
   logic             active;

   tick_divider #(.div(key_div)) u_key_div (.clk(clk), .rst(rst), .tick(key_tick));
   tick_divider #(.div(mole_div)) u_mole_div (.clk(clk), .rst(rst), .tick(mole_tick));
   tick_divider #(.div(dot_div)) u_dot_div (.clk(clk), .rst(rst), .tick(dot_tick));

   keypad_scan u_keypad (
      .clk(clk), .rst(rst), .key_tick(key_tick),
      .keypad_col(keypad_col), .keypad_row(keypad_row), .press(press)
   );

   mole_sequencer u_mole (.clk(clk), .rst(rst), .mole_tick(mole_tick), .mole(mole));

   score_timer u_score (
      .clk(clk), .rst(rst), .mole_tick(mole_tick), .press(press), .mole(mole),
      .score(score), .time_left(time_left), .active(active)
   );

   dot_matrix_scan u_matrix (
      .clk(clk), .rst(rst), .dot_tick(dot_tick), .mole(mole), .active(active),
      .dot_row(dot_row), .dot_col(dot_col)
   );

   seg_pair_decoder u_score_seg (.value(score), .seg(score_seg));
   seg_pair_decoder u_time_seg (.value({2'b00, time_left}), .seg(time_seg));

endmodule

/* testbench/whack_tb.sv */
`timescale 1ns/10ps

module whack_tb;

   localparam int key_div = 4;
   localparam int mole_div = 400;
   localparam int dot_div = 2;
   localparam int clk_period = 8;
   localparam int hold_ticks = 12;
   localparam int watchdog_ns = (mole_pkg::game_time + 2) * mole_div * clk_period * 2;
   localparam int blank_code = 16;   // frame with nothing lit
   localparam int bad_code = 17;     // frame that is no clean 2x2 block

   // active low segments with bit 0 as a and bit 6 as g
   localparam logic [6:0] font_ref [0:9] = '{
      7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
      7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000
   };

   logic                clk;
   logic                rst;
   logic                key_on;
   int                  key_hole;
   logic [3:0]          keypad_col;
   logic [3:0]          keypad_row;
   logic [7:0]          dot_row;
   logic [7:0]          dot_col;
   mole_pkg::seg_pair_t score_seg;
   mole_pkg::seg_pair_t time_seg;

   int   errors = 0;
   int   checks = 0;
   int   cur_code = blank_code;
   int   steps = 0;
   logic watch_blank = 1'b0;
   logic blank_bad = 1'b0;

   whack_top #(
      .key_div(key_div),
      .mole_div(mole_div),
      .dot_div(dot_div)
   ) DUT (
      .clk(clk), .rst(rst), .keypad_col(keypad_col), .keypad_row(keypad_row),
      .dot_row(dot_row), .dot_col(dot_col), .score_seg(score_seg), .time_seg(time_seg)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // held key pulls its column low while its row is driven
   always_comb begin
      keypad_col = '1;
      if (key_on && !keypad_row[3 - key_hole / 4])
         keypad_col[3 - key_hole % 4] = 1'b0;
   end

   always @(negedge clk) begin
      if (watch_blank && dot_col != '0)
         blank_bad = 1'b1;
   end

   initial begin
      #(watchdog_ns);
      $display("timeout: run did not finish within %0d ns", watchdog_ns);
      $display("TESTS FAILED");
      $finish;
   end

   task automatic check_value(input int got, input int expected, input string what);
      checks++;
      if (got != expected) begin
         $display("Fail at %0t ns: %s (got %0h, expected %0h)", $time, what, got, expected);
         errors++;
      end
   endtask

   function automatic logic [13:0] seg_pair(input int v);
      return {font_ref[v / 10], font_ref[v % 10]};
   endfunction

   function automatic int unsigned lcg_next(input int unsigned s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // lit block covers rows 2*(h/4) and 2*(h/4)+1 and a column pair set by h%4
   function automatic int decode_frame(input logic [63:0] f);
      int         lit;
      int         first;
      logic [7:0] c;
      lit = 0;
      first = -1;
      for (int r = 0; r < 8; r++) begin
         if (f[r*8 +: 8] != '0) begin
            lit++;
            if (first < 0)
               first = r;
         end
      end
      if (lit == 0)
         return blank_code;
      if (lit != 2 || first % 2 != 0)
         return bad_code;
      c = f[first*8 +: 8];
      if (f[(first+1)*8 +: 8] != c)
         return bad_code;
      for (int k = 0; k < 4; k++) begin
         if (c == (8'hc0 >> (2 * k)))
            return (first / 2) * 4 + k;
      end
      return bad_code;
   endfunction

   // one low row line rotating from bit 3 down to bit 0
   task automatic check_row_scan;
      logic [3:0] prev;
      logic [3:0] want;
      int         waited;
      prev = keypad_row;
      check_value(prev, 4'b0111, "keypad row after reset");
      for (int k = 1; k <= 4; k++) begin
         want = ~(4'b1000 >> (k % 4));
         waited = 0;
         while (keypad_row == prev && waited < 2 * key_div) begin
            @(negedge clk);
            waited++;
         end
         check_value(keypad_row, want, $sformatf("keypad row at scan step %0d", k));
         prev = keypad_row;
      end
   endtask

   task automatic read_frame(output int code);
      logic [63:0] f;
      f = '0;
      repeat (8 * dot_div) begin
         @(negedge clk);
         for (int r = 0; r < 8; r++) begin
            if (dot_row == ~(8'h80 >> r))
               f[r*8 +: 8] = dot_col;
         end
      end
      code = decode_frame(f);
   endtask

   // needs two equal frames so a frame torn by a mole change is dropped
   task automatic read_stable(output int code);
      int a;
      int b;
      read_frame(a);
      read_frame(b);
      while (a != b || b == bad_code) begin
         a = b;
         read_frame(b);
      end
      code = b;
   endtask

   task automatic track_mole;
      int code;
      read_stable(code);
      if (code != cur_code) begin
         if (code < mole_pkg::holes) begin
            steps++;
            check_value(code, mole_pkg::mole_order[(steps - 1) % mole_pkg::holes],
                        $sformatf("hole shown at mole step %0d", steps));
            check_value(time_seg, seg_pair(mole_pkg::game_time - steps),
                        $sformatf("time display at mole step %0d", steps));
         end
         cur_code = code;
      end
   endtask

   task automatic press_key(input int hole);
      @(posedge clk);
      #1;
      key_hole = hole;
      key_on = 1'b1;
      repeat (hold_ticks * key_div) @(posedge clk);
      #1;
      key_on = 1'b0;
      repeat (4 * key_div) @(posedge clk);   // one full scan clears the key
      @(negedge clk);
   endtask

   task automatic play_line(input int wait_hole, input int hole, input int expected);
      while (cur_code != wait_hole && cur_code != blank_code)
         track_mole;
      if (cur_code != wait_hole) begin
         $display("game ended before hole %0d was shown", wait_hole);
         errors++;
      end else begin
         press_key(hole);
         check_value(score_seg, seg_pair(expected),
                     $sformatf("score after pressing hole %0d on mole %0d", hole, wait_hole));
      end
   endtask

   initial begin
      int          fd;
      int          n;
      int          wait_hole;
      int          hole;
      int          expected;
      int          score_exp;
      int unsigned seed;
      string       line;
      rst = 1'b0;
      key_on = 1'b0;
      key_hole = 0;
      score_exp = 0;
      seed = 32'h98fb;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b1;
      @(negedge clk);
      check_value(time_seg, seg_pair(mole_pkg::game_time), "time display after reset");
      check_value(score_seg, seg_pair(0), "score display after reset");
      check_value(dot_row, 8'hff, "matrix rows after reset");
      check_value(dot_col, 0, "matrix columns after reset");

      watch_blank = 1'b1;
      check_row_scan;
      repeat (mole_div - 40) @(posedge clk);   // first mole lands at mole_div
      watch_blank = 1'b0;
      check_value(blank_bad, 0, "matrix lit before first mole step");
      while (cur_code >= mole_pkg::holes)
         track_mole;

      fd = $fopen("testbench/whack_patterns.txt", "r");
      if (fd == 0) begin
         $display("could not open testbench/whack_patterns.txt");
         errors++;
      end else begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0) begin
               if ($sscanf(line, "%d %d %d", wait_hole, hole, expected) == 3) begin
                  play_line(wait_hole, hole, expected);
                  score_exp = expected;
               end
            end
         end
         $fclose(fd);
      end

      while (cur_code != blank_code)
         track_mole;
      check_value(steps, mole_pkg::game_time - 1, "mole steps shown before game end");
      check_value(time_seg, seg_pair(0), "time display at game end");

      // after game over no press scores and the matrix stays dark
      blank_bad = 1'b0;
      watch_blank = 1'b1;
      press_key(mole_pkg::mole_order[(mole_pkg::game_time - 1) % mole_pkg::holes]);
      check_value(score_seg, seg_pair(score_exp), "hidden mole scored after game end");
      repeat (8) begin
         seed = lcg_next(seed);
         press_key((seed >> 16) % mole_pkg::holes);
         check_value(score_seg, seg_pair(score_exp), "score changed after game end");
      end
      repeat (mole_div) @(posedge clk);
      watch_blank = 1'b0;
      check_value(blank_bad, 0, "matrix lit after game end");

      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

/* testbench/whack_patterns.txt */
# columns: wait_hole press_hole expected_score, all decimal
# wait until the mole shows wait_hole, press press_hole, then the score must read expected_score
12 12 1
4 4 2
4 9 2
8 8 3
13 9 3
0 0 4
3 3 5
1 6 5
7 7 6
14 14 7
5 5 8
9 1 8
2 2 9
6 6 10
10 15 10
15 15 11
12 12 12
13 13 13
3 3 14
7 0 14
5 5 15
11 11 16

/* compile.f */
rtl/mole_pkg.sv
rtl/tick_divider.sv
rtl/keypad_scan.sv
rtl/mole_sequencer.sv
rtl/dot_matrix_scan.sv
rtl/score_timer.sv
rtl/seg_pair_decoder.sv
rtl/whack_top.sv
testbench/whack_tb.sv
